// File: tb.f
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
common/bypass_if.sv
core/fetch_stage.sv
core/decode_stage.sv
core/execute_stage.sv
core/memory_stage.sv
core/cpu_core.sv
dv/tb_cpu_core.sv

// File: dv/tb_cpu_core.sv
// ====================
// testbench for the five-stage core, random programs
// checked against an instruction-level model
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module tb_cpu_core;
    import isa_pkg::*;

    localparam int    NUM_PROGS      = 8;
    localparam int    NUM_RAND       = 40;                        // random slots per program
    localparam int    TIMEOUT_CYCLES = NUM_PROGS * (4 * 45 + 40);
    localparam int    IMEM_AW        = $clog2(`CPU_IMEM_WORDS);
    localparam int    DMEM_AW        = $clog2(`CPU_DMEM_WORDS);
    localparam word_t NOP            = 32'h0000_0013;             // addi x0, x0, 0
    localparam word_t ECALL          = 32'h0000_0073;

    logic                clk;
    logic                reset;
    logic                imem_load;
    logic [IMEM_AW-1:0]  imem_load_addr;
    word_t               imem_load_data;
    logic                is_halted;
    logic                store_valid;
    word_t               store_addr;
    word_t               store_data;

    word_t prog [`CPU_IMEM_WORDS];
    int    prog_len;
    word_t ref_regs [`CPU_NUM_REGS];   // model architectural state
    word_t ref_dmem [`CPU_DMEM_WORDS];
    word_t exp_addr [$];               // expected stores in program order
    word_t exp_data [$];
    int    cycle_count;

    cpu_core uut (
        .clk            (clk),
        .reset          (reset),
        .imem_load      (imem_load),
        .imem_load_addr (imem_load_addr),
        .imem_load_data (imem_load_data),
        .is_halted      (is_halted),
        .store_valid    (store_valid),
        .store_addr     (store_addr),
        .store_data     (store_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    // global run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            report_fail($sformatf("timeout: is_halted not reached within %0d cycles",
                                  TIMEOUT_CYCLES));
    end

    // instruction encoders
    function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd, opcode_e opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE}; // sw
    endfunction

    // x0..x7 plus x17, keeps hazards dense
    function automatic reg_idx_t pick_reg();
        int r;
        r = $urandom_range(0, 8);
        return (r == 8) ? reg_idx_t'(`CPU_HALT_REG) : reg_idx_t'(r);
    endfunction

    // rv32i arithmetic as the spec defines it
    function automatic word_t ref_alu(funct3_e f3, bit sub, word_t a, word_t b);
        case (f3)
            F3_ADD:  return sub ? a - b : a + b;
            F3_SLL:  return a << b[4:0];
            F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_XOR:  return a ^ b;
            F3_SRL:  return a >> b[4:0];
            F3_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic ref_write(input reg_idx_t rd, input word_t val);
        if (rd != '0)
            ref_regs[rd] = val; // x0 stays zero
    endtask

    task automatic emit(input word_t inst);
        prog[prog_len] = inst;
        prog_len++;
    endtask

    // one random instruction, executed on the model as it is emitted
    task automatic gen_random();
        int          kind;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [11:0] imm;
        funct3_e     f3;
        kind = $urandom_range(0, 14);
        rd   = pick_reg();
        rs1  = pick_reg();
        rs2  = pick_reg();
        imm  = 12'($urandom_range(0, 4095));
        case (kind)
            0, 1, 8: f3 = F3_ADD;  // 1 is sub
            2:       f3 = F3_SLL;
            3, 9:    f3 = F3_SLT;
            4, 10:   f3 = F3_XOR;
            5:       f3 = F3_SRL;
            6, 11:   f3 = F3_OR;
            default: f3 = F3_AND;
        endcase
        if (kind < 8) begin
            emit(enc_r((kind == 1) ? 7'b0100000 : 7'b0, rs2, rs1, f3, rd));
            ref_write(rd, ref_alu(f3, kind == 1, ref_regs[rs1], ref_regs[rs2]));
        end else if (kind < 13) begin // immediate forms
            emit(enc_i(imm, rs1, f3, rd, OPC_OP_IMM));
            ref_write(rd, ref_alu(f3, 1'b0, ref_regs[rs1], {{20{imm[11]}}, imm}));
        end else begin
            imm = 12'($urandom_range(0, `CPU_DMEM_WORDS - 1) * 4); // x0 base, aligned
            if (kind == 13) begin
                emit(enc_i(imm, 5'd0, 3'b010, rd, OPC_LOAD));
                ref_write(rd, ref_dmem[imm[DMEM_AW+1:2]]);
            end else begin
                emit(enc_s(imm, rs2, 5'd0));
                ref_dmem[imm[DMEM_AW+1:2]] = ref_regs[rs2];
                exp_addr.push_back(word_t'(imm));
                exp_data.push_back(ref_regs[rs2]);
            end
        end
    endtask

    task automatic build_program(input bit early_ecall);
        int          pos;
        logic [11:0] code;
        pos      = early_ecall ? $urandom_range(4, NUM_RAND - 4) : NUM_RAND + 10;
        prog_len = 0;
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < `CPU_NUM_REGS; i++)
            ref_regs[i] = '0;
        for (int i = 0; i < `CPU_DMEM_WORDS; i++)
            ref_dmem[i] = '0;
        for (int i = 0; i < NUM_RAND; i++) begin
            if (i == pos) begin
                code = 12'($urandom_range(0, `CPU_HALT_CODE - 1)); // never the halt code
                emit(enc_i(code, 5'd0, F3_ADD, 5'(`CPU_HALT_REG), OPC_OP_IMM));
                ref_write(5'(`CPU_HALT_REG), word_t'(code));
            end else if (i == pos + 1) begin
                emit(ECALL); // x17 not 10, acts as a nop
            end else begin
                gen_random();
            end
        end
        emit(enc_i(12'(`CPU_HALT_CODE), 5'd0, F3_ADD, 5'(`CPU_HALT_REG), OPC_OP_IMM));
        emit(ECALL);
        repeat (4) emit(NOP); // tail keeps stale words out of the pipe
    endtask

    // program goes in while reset is held
    task automatic load_program();
        @(posedge clk);
        #1;
        reset = 1'b1;
        for (int i = 0; i < prog_len; i++) begin
            imem_load      = 1'b1;
            imem_load_addr = IMEM_AW'(i);
            imem_load_data = prog[i];
            @(posedge clk);
            #1;
        end
        imem_load = 1'b0;
        @(negedge clk);
        assert (store_valid === 1'b0)
            else report_fail($sformatf("FAIL t=%0t store_valid got %b expected 0",
                                       $time, store_valid));
        assert (is_halted === 1'b0)
            else report_fail($sformatf("FAIL t=%0t is_halted got %b expected 0",
                                       $time, is_halted));
        @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic check_store();
        word_t ea;
        word_t ed;
        assert (exp_addr.size() != 0)
            else report_fail($sformatf("store at t=%0t with no store left in the program",
                                       $time));
        ea = exp_addr.pop_front();
        ed = exp_data.pop_front();
        assert (store_addr === ea)
            else report_fail($sformatf("FAIL t=%0t store_addr got %h expected %h",
                                       $time, store_addr, ea));
        assert (store_data === ed)
            else report_fail($sformatf("FAIL t=%0t store_data got %h expected %h",
                                       $time, store_data, ed));
    endtask

    // outputs sampled mid-cycle
    task automatic run_to_halt();
        bit done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (store_valid === 1'b1)
                check_store();
            if (is_halted === 1'b1)
                done = 1'b1;
        end
        assert (exp_addr.size() == 0)
            else report_fail($sformatf("halted at t=%0t with %0d stores still missing",
                                       $time, exp_addr.size()));
    endtask

    initial begin
        reset          = 1'b1;
        imem_load      = 1'b0;
        imem_load_addr = '0;
        imem_load_data = '0;
        void'($urandom(10628));
        for (int n = 0; n < NUM_PROGS; n++) begin
            build_program(n % 2 == 1); // odd programs get an early ecall
            load_program();
            run_to_halt();
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: core/cpu_core.sv
// ====================
// rv32i five-stage core, top level
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_core (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               imem_load,      // one word per strobe
    input  logic [$clog2(`CPU_IMEM_WORDS)-1:0] imem_load_addr, // word address
    input  isa_pkg::word_t                     imem_load_data,
    output logic                               is_halted,
    output logic                               store_valid,
    output isa_pkg::word_t                     store_addr,
    output isa_pkg::word_t                     store_data
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic     stall;
    word_t    fd_inst;
    ctrl_t    de_ctrl;
    alu_op_e  de_alu_op;
    reg_idx_t de_rs1;
    reg_idx_t de_rs2;
    reg_idx_t de_rd;
    word_t    de_rs1_data;
    word_t    de_rs2_data;
    word_t    de_imm;
    logic     de_halt;
    ctrl_t    em_ctrl;
    reg_idx_t em_rd;
    word_t    em_alu_out;
    word_t    em_store_data;
    logic     em_halt;

    bypass_if bypass ();

    fetch_stage u_fetch (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .imem_load      (imem_load),
        .imem_load_addr (imem_load_addr),
        .imem_load_data (imem_load_data),
        .fd_inst        (fd_inst),
        .fd_pc          ()              // no consumer without branches
    );

    decode_stage u_decode (
        .clk         (clk),
        .reset       (reset),
        .fd_inst     (fd_inst),
        .bypass      (bypass.sink),
        .stall       (stall),
        .de_ctrl     (de_ctrl),
        .de_alu_op   (de_alu_op),
        .de_rs1      (de_rs1),
        .de_rs2      (de_rs2),
        .de_rd       (de_rd),
        .de_rs1_data (de_rs1_data),
        .de_rs2_data (de_rs2_data),
        .de_imm      (de_imm),
        .de_halt     (de_halt)
    );

    execute_stage u_execute (
        .clk           (clk),
        .reset         (reset),
        .de_ctrl       (de_ctrl),
        .de_alu_op     (de_alu_op),
        .de_rs1        (de_rs1),
        .de_rs2        (de_rs2),
        .de_rd         (de_rd),
        .de_rs1_data   (de_rs1_data),
        .de_rs2_data   (de_rs2_data),
        .de_imm        (de_imm),
        .de_halt       (de_halt),
        .bypass        (bypass.sink),
        .em_ctrl       (em_ctrl),
        .em_rd         (em_rd),
        .em_alu_out    (em_alu_out),
        .em_store_data (em_store_data),
        .em_halt       (em_halt)
    );

    memory_stage u_memory (
        .clk           (clk),
        .reset         (reset),
        .em_ctrl       (em_ctrl),
        .em_rd         (em_rd),
        .em_alu_out    (em_alu_out),
        .em_store_data (em_store_data),
        .em_halt       (em_halt),
        .store_valid   (store_valid),
        .store_addr    (store_addr),
        .store_data    (store_data),
        .is_halted     (is_halted),
        .bypass        (bypass.source)
    );

endmodule

`default_nettype wire

// File: core/memory_stage.sv
// ====================
// memory: data memory, mem/wb register, bypass source
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module memory_stage (
    input  logic              clk,
    input  logic              reset,
    input  pipe_pkg::ctrl_t   em_ctrl,
    input  isa_pkg::reg_idx_t em_rd,
    input  isa_pkg::word_t    em_alu_out,
    input  isa_pkg::word_t    em_store_data,
    input  logic              em_halt,
    output logic              store_valid,
    output isa_pkg::word_t    store_addr,
    output isa_pkg::word_t    store_data,
    output logic              is_halted,
    bypass_if.source          bypass
);
    import isa_pkg::*;

    localparam int DMEM_AW = $clog2(`CPU_DMEM_WORDS);

    word_t    dmem [`CPU_DMEM_WORDS];
    word_t    load_data;
    logic     mw_reg_write;
    logic     mw_mem_to_reg;
    reg_idx_t mw_rd;
    word_t    mw_alu_out;
    word_t    mw_load_data;
    logic     mw_halt;

    // data array, word addressed by alu result
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_DMEM_WORDS; i++)
                dmem[i] <= '0;
        end else if (em_ctrl.mem_write) begin
            dmem[em_alu_out[DMEM_AW+1:2]] <= em_store_data;
        end
    end

    assign load_data = em_ctrl.mem_read ? dmem[em_alu_out[DMEM_AW+1:2]] : '0;

    // store strobe, one cycle per sw
    assign store_valid = em_ctrl.mem_write;
    assign store_addr  = em_alu_out;
    assign store_data  = em_store_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            mw_reg_write  <= 1'b0;
            mw_mem_to_reg <= 1'b0;
            mw_rd         <= '0;
            mw_halt       <= 1'b0;
        end else begin
            mw_reg_write  <= em_ctrl.reg_write;
            mw_mem_to_reg <= em_ctrl.mem_to_reg;
            mw_rd         <= em_rd;
            mw_halt       <= mw_halt | em_halt; // sticky until reset
        end
    end

    always_ff @(posedge clk) begin
        mw_alu_out   <= em_alu_out;
        mw_load_data <= load_data;
    end

    assign is_halted = mw_halt;

    // forwarding sources
    assign bypass.mem_rd        = em_rd;
    assign bypass.mem_reg_write = em_ctrl.reg_write;
    assign bypass.mem_value     = em_alu_out;
    assign bypass.mem_is_load   = em_ctrl.mem_read;
    assign bypass.wb_rd         = mw_rd;
    assign bypass.wb_reg_write  = mw_reg_write;
    assign bypass.wb_value      = mw_mem_to_reg ? mw_load_data : mw_alu_out;

endmodule

`default_nettype wire

// File: core/execute_stage.sv
// ====================
// execute: operand forwarding, alu, ex/mem register
// ====================
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic              clk,
    input  logic              reset,
    input  pipe_pkg::ctrl_t   de_ctrl,
    input  isa_pkg::alu_op_e  de_alu_op,
    input  isa_pkg::reg_idx_t de_rs1,
    input  isa_pkg::reg_idx_t de_rs2,
    input  isa_pkg::reg_idx_t de_rd,
    input  isa_pkg::word_t    de_rs1_data,
    input  isa_pkg::word_t    de_rs2_data,
    input  isa_pkg::word_t    de_imm,
    input  logic              de_halt,
    bypass_if.sink            bypass,
    output pipe_pkg::ctrl_t   em_ctrl,
    output isa_pkg::reg_idx_t em_rd,
    output isa_pkg::word_t    em_alu_out,
    output isa_pkg::word_t    em_store_data,
    output logic              em_halt
);
    import isa_pkg::*;
    import pipe_pkg::*;

    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    word_t    op_a;
    word_t    op_b_fwd; // also the store data
    word_t    op_b;
    word_t    alu_res;

    // memory stage is newer, so it wins; x0 never forwarded
    function automatic fwd_sel_e pick_src(reg_idx_t rs, reg_idx_t mem_rd, logic mem_we,
                                          reg_idx_t wb_rd, logic wb_we);
        if (rs != '0 && mem_we && mem_rd == rs)
            return FWD_MEM;
        if (rs != '0 && wb_we && wb_rd == rs)
            return FWD_WB;
        return FWD_REG;
    endfunction

    function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t mem_val,
                                      word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign fwd_a = pick_src(de_rs1, bypass.mem_rd, bypass.mem_reg_write,
                            bypass.wb_rd, bypass.wb_reg_write);
    assign fwd_b = pick_src(de_rs2, bypass.mem_rd, bypass.mem_reg_write,
                            bypass.wb_rd, bypass.wb_reg_write);

    assign op_a     = fwd_mux(fwd_a, de_rs1_data, bypass.mem_value, bypass.wb_value);
    assign op_b_fwd = fwd_mux(fwd_b, de_rs2_data, bypass.mem_value, bypass.wb_value);
    assign op_b     = de_ctrl.alu_src ? de_imm : op_b_fwd; // immediate forms

    always_comb begin
        case (de_alu_op)
            ALU_ADD: alu_res = op_a + op_b;
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_XOR: alu_res = op_a ^ op_b;
            ALU_SLT: alu_res = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLL: alu_res = op_a << op_b[4:0]; // shamt is low 5 bits
            ALU_SRL: alu_res = op_a >> op_b[4:0];
            default: alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            em_ctrl <= '0;
            em_rd   <= '0;
            em_halt <= 1'b0;
        end else begin
            em_ctrl <= de_ctrl;
            em_rd   <= de_rd;
            em_halt <= de_halt;
        end
    end

    always_ff @(posedge clk) begin
        em_alu_out    <= alu_res;
        em_store_data <= op_b_fwd;
    end

endmodule

`default_nettype wire

// File: core/decode_stage.sv
// ====================
// decode: control, immediates, register file,
// hazard stall, ecall halt, id/ex register
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module decode_stage (
    input  logic              clk,
    input  logic              reset,
    input  isa_pkg::word_t    fd_inst,
    bypass_if.sink            bypass,
    output logic              stall,
    output pipe_pkg::ctrl_t   de_ctrl,
    output isa_pkg::alu_op_e  de_alu_op,
    output isa_pkg::reg_idx_t de_rs1,
    output isa_pkg::reg_idx_t de_rs2,
    output isa_pkg::reg_idx_t de_rd,
    output isa_pkg::word_t    de_rs1_data,
    output isa_pkg::word_t    de_rs2_data,
    output isa_pkg::word_t    de_imm,
    output logic              de_halt
);
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam reg_idx_t HALT_REG = reg_idx_t'(`CPU_HALT_REG);

    word_t    regs [`CPU_NUM_REGS];
    opcode_e  opcode;
    funct3_e  funct3;
    ctrl_t    ctrl;
    alu_op_e  alu_op;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    imm;
    word_t    ecall_val;
    logic     uses_rs2;
    logic     load_use;
    logic     ecall_wait;
    logic     halt;

    assign opcode = opcode_e'(fd_inst[6:0]);
    assign funct3 = funct3_e'(fd_inst[14:12]);

    always_comb begin
        ctrl     = '0;
        alu_op   = ALU_ADD; // address calc default
        uses_rs2 = 1'b0;
        case (opcode)
            OPC_OP: begin
                ctrl.reg_write = 1'b1;
                uses_rs2       = 1'b1;
            end
            OPC_OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            OPC_LOAD: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            OPC_STORE: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
                uses_rs2       = 1'b1; // store data
            end
            OPC_SYSTEM: ctrl.is_ecall = 1'b1;
            default: ;
        endcase
        // arithmetic ops from funct3
        if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
            case (funct3)
                F3_ADD: alu_op = (opcode == OPC_OP && fd_inst[30]) ? ALU_SUB : ALU_ADD;
                F3_SLL: alu_op = ALU_SLL;
                F3_SLT: alu_op = ALU_SLT;
                F3_XOR: alu_op = ALU_XOR;
                F3_SRL: alu_op = ALU_SRL;
                F3_OR:  alu_op = ALU_OR;
                F3_AND: alu_op = ALU_AND;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    // i-type, or s-type for stores
    assign imm = (opcode == OPC_STORE) ?
                 {{20{fd_inst[31]}}, fd_inst[31:25], fd_inst[11:7]} :
                 {{20{fd_inst[31]}}, fd_inst[31:20]};

    assign rs1 = ctrl.is_ecall ? HALT_REG : fd_inst[19:15]; // ecall reads x17
    assign rs2 = fd_inst[24:20];

    // register file, written from writeback, x0 stays zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++)
                regs[i] <= '0;
        end else if (bypass.wb_reg_write && bypass.wb_rd != '0) begin
            regs[bypass.wb_rd] <= bypass.wb_value;
        end
    end

    // same-cycle write shows through to the read
    assign rs1_data = (bypass.wb_reg_write && rs1 != '0 && bypass.wb_rd == rs1) ?
                      bypass.wb_value : regs[rs1];
    assign rs2_data = (bypass.wb_reg_write && rs2 != '0 && bypass.wb_rd == rs2) ?
                      bypass.wb_value : regs[rs2];

    // x17 for ecall, newer alu result in ex/mem wins
    assign ecall_val = (bypass.mem_reg_write && bypass.mem_rd == HALT_REG) ?
                       bypass.mem_value : rs1_data;
    assign halt = ctrl.is_ecall && ecall_val == word_t'(`CPU_HALT_CODE);

    // load in id/ex feeding this instruction
    assign load_use = de_ctrl.mem_read && de_rd != '0 &&
                      ((rs1 != '0 && rs1 == de_rd) || (uses_rs2 && rs2 != '0 && rs2 == de_rd));
    // x17 not yet visible to decode
    assign ecall_wait = ctrl.is_ecall &&
                        ((de_ctrl.reg_write && de_rd == HALT_REG) ||
                         (bypass.mem_is_load && bypass.mem_reg_write &&
                          bypass.mem_rd == HALT_REG));
    assign stall = load_use || ecall_wait;

    always_ff @(posedge clk) begin
        if (reset || stall) begin // bubble
            de_ctrl <= '0;
            de_rd   <= '0;
            de_halt <= 1'b0;
        end else begin
            de_ctrl <= ctrl;
            de_rd   <= fd_inst[11:7];
            de_halt <= halt;
        end
    end

    // operand payload
    always_ff @(posedge clk) begin
        de_alu_op   <= alu_op;
        de_rs1      <= rs1;
        de_rs2      <= rs2;
        de_rs1_data <= rs1_data;
        de_rs2_data <= rs2_data;
        de_imm      <= imm;
    end

endmodule

`default_nettype wire

// File: core/fetch_stage.sv
// ====================
// fetch: pc, instruction memory, if/id register
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module fetch_stage (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               stall,
    input  logic                               imem_load,
    input  logic [$clog2(`CPU_IMEM_WORDS)-1:0] imem_load_addr,
    input  isa_pkg::word_t                     imem_load_data,
    output isa_pkg::word_t                     fd_inst,
    output isa_pkg::word_t                     fd_pc
);
    import isa_pkg::*;

    localparam int IMEM_AW = $clog2(`CPU_IMEM_WORDS);
    localparam word_t NOP = 32'h0000_0013; // addi x0, x0, 0

    word_t imem [`CPU_IMEM_WORDS];
    word_t pc;
    word_t inst;

    // program load port, also live during reset
    always_ff @(posedge clk) begin
        if (imem_load)
            imem[imem_load_addr] <= imem_load_data;
    end

    assign inst = imem[pc[IMEM_AW+1:2]]; // word addressed, async read

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= '0;
            fd_inst <= NOP; // start with a bubble
            fd_pc   <= '0;
        end else if (!stall) begin // hold pc and if/id on load-use or ecall wait
            pc      <= pc + 32'd4;
            fd_inst <= inst;
            fd_pc   <= pc;
        end
    end

endmodule

`default_nettype wire

// File: common/bypass_if.sv
// ====================
// bypass bundle, memory and writeback results
// ====================
`timescale 1ns/1ps
`default_nettype none

interface bypass_if;
    import isa_pkg::*;

    reg_idx_t mem_rd;        // ex/mem destination
    logic     mem_reg_write;
    word_t    mem_value;     // ex/mem alu result
    logic     mem_is_load;   // value not ready yet
    reg_idx_t wb_rd;
    logic     wb_reg_write;
    word_t    wb_value;      // after load/alu select

    modport source (
        output mem_rd, mem_reg_write, mem_value, mem_is_load,
        output wb_rd, wb_reg_write, wb_value
    );

    modport sink (
        input mem_rd, mem_reg_write, mem_value, mem_is_load,
        input wb_rd, wb_reg_write, wb_value
    );

endinterface

`default_nettype wire

// File: common/pipe_pkg.sv
// ====================
// pipeline control and forwarding types
// ====================
`default_nettype none

package pipe_pkg;

    // control bits carried down the pipe
    typedef struct packed {
        logic alu_src;    // operand 2 from immediate
        logic mem_read;   // lw
        logic mem_write;  // sw
        logic reg_write;
        logic mem_to_reg; // writeback takes load data
        logic is_ecall;
    } ctrl_t;

    // operand source at execute
    typedef enum logic [1:0] {
        FWD_REG, // value read in decode
        FWD_MEM, // ex/mem alu result
        FWD_WB   // final writeback value
    } fwd_sel_e;

endpackage

`default_nettype wire

// File: common/isa_pkg.sv
// ====================
// rv32i encoding types for the kept subset
// ====================
`default_nettype none

`include "cpu_config.svh"

package isa_pkg;

    typedef logic [4:0]           reg_idx_t; // register index field
    typedef logic [`CPU_XLEN-1:0] word_t;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_SYSTEM = 7'b1110011  // ecall only
    } opcode_e;

    // arithmetic funct3, inst[14:12]
    typedef enum logic [2:0] {
        F3_ADD = 3'b000, // add, sub, addi
        F3_SLL = 3'b001,
        F3_SLT = 3'b010,
        F3_XOR = 3'b100,
        F3_SRL = 3'b101,
        F3_OR  = 3'b110,
        F3_AND = 3'b111
    } funct3_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,  // signed compare
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

endpackage

`default_nettype wire

// File: common/cpu_config.svh
// ====================
// core configuration: widths, depths, halt convention
// ====================
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath and address width
`define CPU_XLEN        32
`define CPU_NUM_REGS    32

// memory depths in words
`define CPU_IMEM_WORDS  256
`define CPU_DMEM_WORDS  64

// ecall halts when this register holds this code
`define CPU_HALT_REG    17
`define CPU_HALT_CODE   10

`endif
